// File: Bender.yml
package:
  name: conv_pool

sources:
  - rtl/conv_pool_pkg.sv
  - rtl/window_loader.sv
  - rtl/channel_mac.sv
  - rtl/pool_requant.sv
  - rtl/conv_pool_top.sv
  - target: simulation
    files:
      - verification/conv_pool_tb.sv

// File: rtl/channel_mac.sv
`timescale 1ns/1ps

module channel_mac (
	input  logic clk,
	input  logic rst_n,
	input  logic advance,
	input  conv_pool_pkg::lane_in_t lane_in,
	output conv_pool_pkg::acc_t lane_sum
);

	conv_pool_pkg::acc_t [conv_pool_pkg::TAPS-1:0] prod;
	conv_pool_pkg::acc_t [3:0] pair_sum;
	conv_pool_pkg::acc_t [1:0] quad_sum;
	conv_pool_pkg::acc_t dot;

	// signed 12x8 products, sign extended to the lane width
	always_comb begin
		for (int t = 0; t < conv_pool_pkg::TAPS; t++) begin
			prod[t] = conv_pool_pkg::acc_t'($signed(lane_in.act[t]))
				* conv_pool_pkg::acc_t'($signed(lane_in.weight[t]));
		end
	end

	// adder tree, tap 8 joins at the last level
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			pair_sum[p] = prod[2*p] + prod[2*p+1];
		end
		quad_sum[0] = pair_sum[0] + pair_sum[1];
		quad_sum[1] = pair_sum[2] + pair_sum[3];
		dot = quad_sum[0] + quad_sum[1] + prod[8];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lane_sum <= '0;
		end else if (advance) begin
			lane_sum <= dot;
		end
	end

endmodule

// File: rtl/conv_pool_pkg.sv
package conv_pool_pkg;

	// default number of input channels held by one kernel
	parameter int CH_NUM_DEF = 4;

	parameter int ACT_W = 12;
	parameter int PARAM_W = 8;
	parameter int TAPS = 9;

	// one lane dot product, 9 products of 12x8 bits
	parameter int PROD_W = 21;

	// bias is aligned to the product scale before the add
	parameter int BIAS_SHIFT = 8;

	// requantization of the pooled average
	parameter int ROUND_ADD = 64;
	parameter int QUANT_SHIFT = 7;
	parameter int OUT_MAX = 2047;

	// windows per 2x2 pooling block
	parameter int POOL_SIZE = 4;

	typedef logic signed [ACT_W-1:0] act_t;
	typedef logic signed [PARAM_W-1:0] param_t;
	typedef logic signed [PROD_W-1:0] acc_t;
	typedef logic [ACT_W-1:0] out_t;

	// operands of one channel lane
	typedef struct packed {
		act_t [TAPS-1:0] act;
		param_t [TAPS-1:0] weight;
	} lane_in_t;

	// control that follows lane_sum into the pooling stage
	typedef struct packed {
		logic valid;
		logic last;
		param_t bias;
	} stage_ctl_t;

endpackage

// File: rtl/conv_pool_top.sv
`timescale 1ns/1ps

module conv_pool_top #(
	parameter int CH_NUM = conv_pool_pkg::CH_NUM_DEF
) (
	input  logic clk,
	input  logic rst_n,
	input  logic kernel_valid,
	input  conv_pool_pkg::param_t [CH_NUM-1:0][conv_pool_pkg::TAPS-1:0] kernel_weights,
	input  conv_pool_pkg::param_t kernel_bias,
	input  logic win_valid,
	input  conv_pool_pkg::act_t [CH_NUM-1:0][conv_pool_pkg::TAPS-1:0] win_act,
	output logic win_ready,
	output logic out_valid,
	output conv_pool_pkg::out_t out_data,
	input  logic out_ready
);

	logic advance;
	logic stage_valid;
	logic group_last;
	conv_pool_pkg::lane_in_t [CH_NUM-1:0] lane_in;
	conv_pool_pkg::acc_t [CH_NUM-1:0] lane_sum;
	conv_pool_pkg::param_t kernel_bias_q;

	window_loader #(
		.CH_NUM(CH_NUM)
	) loader_i (
		.clk(clk),
		.rst_n(rst_n),
		.kernel_valid(kernel_valid),
		.kernel_weights(kernel_weights),
		.kernel_bias(kernel_bias),
		.win_valid(win_valid),
		.win_act(win_act),
		.advance(advance),
		.win_ready(win_ready),
		.lane_in(lane_in),
		.stage_valid(stage_valid),
		.group_last(group_last),
		.kernel_bias_q(kernel_bias_q)
	);

	// one MAC lane per input channel
	for (genvar c = 0; c < CH_NUM; c++) begin : g_lane
		channel_mac mac_i (
			.clk(clk),
			.rst_n(rst_n),
			.advance(advance),
			.lane_in(lane_in[c]),
			.lane_sum(lane_sum[c])
		);
	end

	pool_requant #(
		.CH_NUM(CH_NUM)
	) pool_i (
		.clk(clk),
		.rst_n(rst_n),
		.lane_sum(lane_sum),
		.stage_valid(stage_valid),
		.group_last(group_last),
		.kernel_bias_q(kernel_bias_q),
		.out_ready(out_ready),
		.advance(advance),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

// File: rtl/pool_requant.sv
`timescale 1ns/1ps

module pool_requant #(
	parameter int CH_NUM = conv_pool_pkg::CH_NUM_DEF
) (
	input  logic clk,
	input  logic rst_n,
	input  conv_pool_pkg::acc_t [CH_NUM-1:0] lane_sum,
	input  logic stage_valid,
	input  logic group_last,
	input  conv_pool_pkg::param_t kernel_bias_q,
	input  logic out_ready,
	output logic advance,
	output logic out_valid,
	output conv_pool_pkg::out_t out_data
);

	// headroom for the channel sum and for the four window group total
	localparam int POOL_SHIFT = $clog2(conv_pool_pkg::POOL_SIZE);
	localparam int SUM_W = conv_pool_pkg::PROD_W + $clog2(CH_NUM) + 1;
	localparam int GRP_W = SUM_W + POOL_SHIFT;

	conv_pool_pkg::stage_ctl_t ctl_q;
	logic signed [SUM_W-1:0] total;
	logic [GRP_W-1:0] relu;
	logic [GRP_W-1:0] acc;
	logic [GRP_W-1:0] grp_next;
	logic [GRP_W-1:0] avg;
	logic [GRP_W-1:0] rounded;
	logic [GRP_W-1:0] scaled;
	conv_pool_pkg::out_t quant;

	// output register empty or being drained
	assign advance = !out_valid || out_ready;

	// channel sum plus aligned bias, then ReLU
	always_comb begin
		total = SUM_W'($signed(ctl_q.bias));
		total = total <<< conv_pool_pkg::BIAS_SHIFT;
		for (int c = 0; c < CH_NUM; c++) begin
			total = total + SUM_W'($signed(lane_sum[c]));
		end
		relu = total[SUM_W-1] ? '0 : GRP_W'(total);
	end

	// average of the group, rounded and saturated
	always_comb begin
		grp_next = acc + relu;
		avg = grp_next >> POOL_SHIFT;
		rounded = avg + GRP_W'(conv_pool_pkg::ROUND_ADD);
		scaled = rounded >> conv_pool_pkg::QUANT_SHIFT;
		if (scaled > GRP_W'(conv_pool_pkg::OUT_MAX)) begin
			quant = conv_pool_pkg::out_t'(conv_pool_pkg::OUT_MAX);
		end else begin
			quant = conv_pool_pkg::out_t'(scaled);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctl_q <= '0;
			acc <= '0;
			out_valid <= 1'b0;
		end else if (advance) begin
			// lines the control up with lane_sum
			ctl_q.valid <= stage_valid;
			ctl_q.last <= group_last;
			ctl_q.bias <= kernel_bias_q;
			out_valid <= ctl_q.valid && ctl_q.last;
			if (ctl_q.valid) begin
				acc <= ctl_q.last ? '0 : grp_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance && ctl_q.valid && ctl_q.last) begin
			out_data <= quant;
		end
	end

	out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

	out_reset_a: assert property (@(posedge clk)
		!rst_n |=> !out_valid);

endmodule

// File: rtl/window_loader.sv
`timescale 1ns/1ps

module window_loader #(
	parameter int CH_NUM = conv_pool_pkg::CH_NUM_DEF
) (
	input  logic clk,
	input  logic rst_n,
	input  logic kernel_valid,
	input  conv_pool_pkg::param_t [CH_NUM-1:0][conv_pool_pkg::TAPS-1:0] kernel_weights,
	input  conv_pool_pkg::param_t kernel_bias,
	input  logic win_valid,
	input  conv_pool_pkg::act_t [CH_NUM-1:0][conv_pool_pkg::TAPS-1:0] win_act,
	input  logic advance,
	output logic win_ready,
	output conv_pool_pkg::lane_in_t [CH_NUM-1:0] lane_in,
	output logic stage_valid,
	output logic group_last,
	output conv_pool_pkg::param_t kernel_bias_q
);

	localparam int POS_W = $clog2(conv_pool_pkg::POOL_SIZE);

	conv_pool_pkg::param_t [CH_NUM-1:0][conv_pool_pkg::TAPS-1:0] weight_q;
	conv_pool_pkg::param_t bias_q;
	conv_pool_pkg::lane_in_t [CH_NUM-1:0] lane_d;
	logic [POS_W-1:0] pos;
	logic pos_last;

	// the whole pipeline moves together, so the loader takes a window on advance
	assign win_ready = advance;
	assign pos_last = (pos == POS_W'(conv_pool_pkg::POOL_SIZE - 1));

	// kernel store
	always_ff @(posedge clk) begin
		if (kernel_valid) begin
			weight_q <= kernel_weights;
			bias_q <= kernel_bias;
		end
	end

	// pair every channel window with its own weights
	always_comb begin
		for (int c = 0; c < CH_NUM; c++) begin
			lane_d[c].act = win_act[c];
			lane_d[c].weight = weight_q[c];
		end
	end

	// lane operands and the bias move with the window
	always_ff @(posedge clk) begin
		if (advance) begin
			lane_in <= lane_d;
			kernel_bias_q <= bias_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos <= '0;
			stage_valid <= 1'b0;
			group_last <= 1'b0;
		end else if (advance) begin
			stage_valid <= win_valid;
			group_last <= win_valid && pos_last;
			if (win_valid) begin
				pos <= pos_last ? '0 : pos + 1'b1;
			end
		end
	end

	// a reload in the middle of a group would mix two kernels in one pooled output
	kernel_between_groups_a: assert property (@(posedge clk) disable iff (!rst_n)
		kernel_valid |-> pos == '0);

	win_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		win_valid && !win_ready |=> win_valid && $stable(win_act));

endmodule

// File: verification/conv_pool_tb.sv
`timescale 1ns/1ps

module conv_pool_tb;

	localparam int CH_NUM = 4;
	localparam int TAPS = conv_pool_pkg::TAPS;
	localparam int NUM_ROWS = 7;
	localparam int MAX_GRP = 40;
	localparam int MAX_WIN = MAX_GRP * 4;
	localparam int TIMEOUT = 200;
	localparam int ROW_CYCLES = 20000;

	localparam int KER_UNIT = 0;
	localparam int KER_MAX = 1;
	localparam int KER_RAND = 2;
	localparam int ACT_FIXED = 0;
	localparam int ACT_NEG = 1;
	localparam int ACT_POS = 2;
	localparam int ACT_RAND = 3;

	typedef struct {
		string name;
		int ker_mode;
		int act_mode;
		int groups;
		bit rand_ready;
		bit reload;
		conv_pool_pkg::act_t seq [8];
		conv_pool_pkg::out_t exp [2];
	} row_t;

	logic clk;
	logic rst_n;
	logic kernel_valid;
	conv_pool_pkg::param_t [CH_NUM-1:0][TAPS-1:0] kernel_weights;
	conv_pool_pkg::param_t kernel_bias;
	logic win_valid;
	conv_pool_pkg::act_t [CH_NUM-1:0][TAPS-1:0] win_act;
	logic win_ready;
	logic out_valid;
	conv_pool_pkg::out_t out_data;
	logic out_ready;

	row_t rows [NUM_ROWS];
	conv_pool_pkg::param_t [CH_NUM-1:0][TAPS-1:0] ker_w [MAX_GRP];
	conv_pool_pkg::param_t ker_b [MAX_GRP];
	conv_pool_pkg::act_t [CH_NUM-1:0][TAPS-1:0] win_tab [MAX_WIN];
	conv_pool_pkg::out_t exp_q [$];
	logic [31:0] lfsr;
	int rx_count;

	conv_pool_top #(
		.CH_NUM(CH_NUM)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.kernel_valid(kernel_valid),
		.kernel_weights(kernel_weights),
		.kernel_bias(kernel_bias),
		.win_valid(win_valid),
		.win_act(win_act),
		.win_ready(win_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_out(input string name, input conv_pool_pkg::out_t exp,
			input conv_pool_pkg::out_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic compare_count(input string name, input int exp, input int act);
		if (act != exp) begin
			stop_on_error($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	// taps 32 22 2 1 with one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// unit kernel rows only look at channel 0 tap 0
	task automatic fill_table();
		rows[0] = '{"known_kernel", KER_UNIT, ACT_FIXED, 2, 1'b0, 1'b0,
			'{1000, 1200, 1400, 1600, 2047, 2047, 2047, 2047}, '{10, 16}};
		rows[1] = '{"relu_negative", KER_UNIT, ACT_NEG, 2, 1'b0, 1'b0,
			'{default: 0}, '{0, 0}};
		rows[2] = '{"relu_mixed", KER_UNIT, ACT_FIXED, 1, 1'b0, 1'b0,
			'{-2000, 1900, -500, 1500, 0, 0, 0, 0}, '{7, 0}};
		rows[3] = '{"saturation", KER_MAX, ACT_POS, 2, 1'b0, 1'b0,
			'{default: 0}, '{2047, 2047}};
		rows[4] = '{"random", KER_RAND, ACT_RAND, 40, 1'b0, 1'b0,
			'{default: 0}, '{0, 0}};
		rows[5] = '{"backpressure", KER_RAND, ACT_RAND, 40, 1'b1, 1'b0,
			'{default: 0}, '{0, 0}};
		rows[6] = '{"kernel_reload", KER_RAND, ACT_RAND, 12, 1'b0, 1'b1,
			'{default: 0}, '{0, 0}};
	endtask

	// four taps of 127 keep one lane inside acc_t with full scale activations
	task automatic make_kernel(input int g, input int mode);
		logic [31:0] bits;
		for (int c = 0; c < CH_NUM; c++) begin
			for (int t = 0; t < TAPS; t++) begin
				case (mode)
					KER_UNIT: ker_w[g][c][t] = (c == 0 && t == 0) ? 8'sd1 : 8'sd0;
					KER_MAX: ker_w[g][c][t] = (t < 4) ? 8'sd127 : 8'sd0;
					default: begin
						bits = rand_bits(6);
						ker_w[g][c][t] = {{2{bits[5]}}, bits[5:0]};
					end
				endcase
			end
		end
		case (mode)
			KER_UNIT: ker_b[g] = 8'sd0;
			KER_MAX: ker_b[g] = 8'sd127;
			default: ker_b[g] = conv_pool_pkg::param_t'(rand_bits(8));
		endcase
	endtask

	task automatic make_window(input int idx, input int mode, input conv_pool_pkg::act_t seed);
		for (int c = 0; c < CH_NUM; c++) begin
			for (int t = 0; t < TAPS; t++) begin
				case (mode)
					ACT_FIXED: win_tab[idx][c][t] = (c == 0 && t == 0) ? seed
						: conv_pool_pkg::act_t'((c * 9 + t) * 53 - 900);
					ACT_NEG: win_tab[idx][c][t] = conv_pool_pkg::act_t'(-2048);
					ACT_POS: win_tab[idx][c][t] = conv_pool_pkg::act_t'(2047);
					default: win_tab[idx][c][t] = conv_pool_pkg::act_t'(rand_bits(12));
				endcase
			end
		end
	endtask

	// ReLU per window, then average of four, round, scale by 2^-7, clip
	function automatic conv_pool_pkg::out_t model_group(input int g);
		longint total;
		longint grp;
		int idx;
		grp = 0;
		for (int w = 0; w < 4; w++) begin
			idx = g * 4 + w;
			total = longint'(ker_b[g]) * 256;
			for (int c = 0; c < CH_NUM; c++) begin
				for (int t = 0; t < TAPS; t++) begin
					total += longint'(win_tab[idx][c][t]) * longint'(ker_w[g][c][t]);
				end
			end
			if (total > 0) begin
				grp += total;
			end
		end
		grp = (grp / 4 + 64) / 128;
		if (grp > 2047) begin
			grp = 2047;
		end
		return conv_pool_pkg::out_t'(grp);
	endfunction

	task automatic build_row(input int r);
		exp_q.delete();
		for (int g = 0; g < rows[r].groups; g++) begin
			if (g == 0 || rows[r].reload) begin
				make_kernel(g, rows[r].ker_mode);
			end else begin
				ker_w[g] = ker_w[g-1];
				ker_b[g] = ker_b[g-1];
			end
			for (int w = 0; w < 4; w++) begin
				make_window(g * 4 + w, rows[r].act_mode, rows[r].seq[(g * 4 + w) % 8]);
			end
			if (rows[r].ker_mode == KER_RAND) begin
				exp_q.push_back(model_group(g));
			end else begin
				exp_q.push_back(rows[r].exp[g]);
			end
		end
	endtask

	// called just after a rising edge and returns just after the transfer edge
	task automatic send_window(input int idx);
		int wait_cnt;
		wait_cnt = 0;
		win_valid <= 1'b1;
		win_act <= win_tab[idx];
		@(negedge clk);
		while (!win_ready) begin
			wait_cnt++;
			if (wait_cnt > TIMEOUT) begin
				stop_on_error("timeout: window was not accepted by the DUT");
			end
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic send_row(input int groups, input bit reload);
		@(posedge clk);
		for (int g = 0; g < groups; g++) begin
			if (g == 0 || reload) begin
				win_valid <= 1'b0;
				kernel_valid <= 1'b1;
				kernel_weights <= ker_w[g];
				kernel_bias <= ker_b[g];
				@(posedge clk);
				kernel_valid <= 1'b0;
			end
			for (int w = 0; w < 4; w++) begin
				send_window(g * 4 + w);
			end
		end
		win_valid <= 1'b0;
	endtask

	task automatic drive_ready(input bit rand_ready, input int groups);
		int cycles;
		logic [31:0] bits;
		cycles = 0;
		while (rx_count < groups) begin
			@(posedge clk);
			if (rand_ready) begin
				bits = rand_bits(1);
				out_ready <= bits[0];
			end else begin
				out_ready <= 1'b1;
			end
			cycles++;
			if (cycles > ROW_CYCLES) begin
				stop_on_error("timeout: row did not finish");
			end
		end
		out_ready <= 1'b1;
	endtask

	// results are sampled mid cycle and transfer at the next rising edge
	task automatic collect_row(input string name, input int groups);
		int idle;
		logic hold;
		conv_pool_pkg::out_t held;
		idle = 0;
		hold = 1'b0;
		held = '0;
		while (rx_count < groups) begin
			@(negedge clk);
			if (hold) begin
				if (!out_valid) begin
					stop_on_error("out_valid dropped while a result was held");
				end
				compare_out($sformatf("%s held group %0d", name, rx_count), held, out_data);
			end
			if (out_valid && out_ready) begin
				compare_out($sformatf("%s group %0d", name, rx_count), exp_q.pop_front(),
					out_data);
				rx_count++;
				idle = 0;
				hold = 1'b0;
			end else begin
				hold = out_valid;
				held = out_data;
				idle++;
				if (idle > TIMEOUT) begin
					stop_on_error("timeout: expected result did not arrive");
				end
			end
		end
	endtask

	task automatic run_row(input int r);
		int extra;
		build_row(r);
		rx_count = 0;
		fork
			send_row(rows[r].groups, rows[r].reload);
			collect_row(rows[r].name, rows[r].groups);
			drive_ready(rows[r].rand_ready, rows[r].groups);
		join
		// anything after the last expected group is a duplicate
		extra = 0;
		repeat (6) begin
			@(negedge clk);
			if (out_valid) begin
				extra++;
			end
		end
		compare_count({rows[r].name, " result count"}, rows[r].groups, rx_count + extra);
	endtask

	initial begin
		lfsr = 32'h15f0ae49;
		rx_count = 0;
		rst_n = 1'b0;
		kernel_valid = 1'b0;
		kernel_weights = '0;
		kernel_bias = '0;
		win_valid = 1'b0;
		win_act = '0;
		out_ready = 1'b1;
		fill_table();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: verilog.f
rtl/conv_pool_pkg.sv
rtl/window_loader.sv
rtl/channel_mac.sv
rtl/pool_requant.sv
rtl/conv_pool_top.sv
verification/conv_pool_tb.sv
